//--- filelist.f
+incdir+source
source/gecko_pkg.sv
source/gecko_fetch.sv
source/gecko_decode.sv
source/gecko_execute.sv
source/gecko_mem_arbiter.sv
source/gecko_memory.sv
source/gecko_core.sv
testbench/gecko_core_tb.sv

//--- Bender.yml
package:
  name: gecko

sources:
  - include_dirs:
      - source
    files:
      - source/gecko_pkg.sv
      - source/gecko_fetch.sv
      - source/gecko_decode.sv
      - source/gecko_execute.sv
      - source/gecko_mem_arbiter.sv
      - source/gecko_memory.sv
      - source/gecko_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/gecko_core_tb.sv

//--- testbench/gecko_core_tb.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_core_tb;

    localparam int NUM_TESTS    = 5;
    localparam int PROG_WORDS   = 16;
    localparam int EXIT_TIMEOUT = 4000;
    localparam int DRAIN_CYCLES = 20;
    localparam logic [31:0] ECALL = 32'h0000_0073;
    localparam logic [31:0] NOP   = 32'h0000_0013;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                prog_we;
    logic [$clog2(`GECKO_MEM_WORDS)-1:0] prog_addr;
    logic [`GECKO_XLEN-1:0]              prog_data;
    logic                                print_valid;
    logic                                print_ready;
    logic [7:0]                          print_data;
    logic                                exit_valid;
    logic [7:0]                          exit_code;

    // stimulus table, one row per program
    string       test_name [NUM_TESTS];
    logic [31:0] prog      [NUM_TESTS][PROG_WORDS];
    logic [7:0]  exp_bytes [NUM_TESTS][8];
    int          exp_count [NUM_TESTS];
    logic [7:0]  exp_exit  [NUM_TESTS];

    logic [7:0]  got_bytes [$];
    logic [31:0] lfsr_state = 32'h2624;
    int          errors = 0;
    int          timeouts = 0;

    gecko_core u_gecko_core (
        .clk, .rst,
        .prog_we, .prog_addr, .prog_data,
        .print_valid, .print_ready, .print_data,
        .exit_valid, .exit_code
    );

    always #50 clk = ~clk;

    // rv32i encoders
    function automatic logic [31:0] addi_op(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_op(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw_op(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_op(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_op(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_op(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk) begin
        lfsr_state = lfsr_step(lfsr_state);
        print_ready <= lfsr_state[0];
    end

    always @(posedge clk) begin
        if (!rst && print_valid && print_ready) begin
            got_bytes.push_back(print_data);
        end
    end

    task automatic fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin
                prog[t][i] = NOP;
            end
        end
        // alu ops, x6 = 0x5a, x9 = 0x0f
        test_name[0] = "alu";
        prog[0][0]  = lui_op(5, 20'h12345);
        prog[0][1]  = addi_op(6, 0, 12'h05A);
        prog[0][2]  = addi_op(9, 0, 12'h00F);
        prog[0][3]  = addi_op(17, 0, `GECKO_ECALL_PRINT);
        prog[0][4]  = r_type(7'h00, 3'b111, 10, 6, 9);
        prog[0][5]  = ECALL;
        prog[0][6]  = r_type(7'h00, 3'b110, 10, 6, 9);
        prog[0][7]  = ECALL;
        prog[0][8]  = r_type(7'h00, 3'b100, 10, 6, 9);
        prog[0][9]  = ECALL;
        prog[0][10] = r_type(7'h20, 3'b000, 10, 5, 6);
        prog[0][11] = ECALL;
        prog[0][12] = addi_op(17, 0, `GECKO_ECALL_EXIT);
        prog[0][13] = r_type(7'h00, 3'b000, 10, 6, 9);
        prog[0][14] = ECALL;
        exp_bytes[0] = '{8'h0A, 8'h5F, 8'h55, 8'hA6, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[0] = 4;
        exp_exit[0]  = 8'h69;
        // word 0xabcde03c stored at 0x204 and read back
        // second print only when all 32 bits match
        test_name[1] = "store_load";
        prog[1][0]  = addi_op(17, 0, `GECKO_ECALL_PRINT);
        prog[1][1]  = lui_op(7, 20'hABCDE);
        prog[1][2]  = addi_op(7, 7, 12'h03C);
        prog[1][3]  = addi_op(8, 0, 12'h200);
        prog[1][4]  = sw_op(7, 8, 12'h004);
        prog[1][5]  = lw_op(11, 8, 12'h004);
        prog[1][6]  = addi_op(10, 11, 12'h000);
        prog[1][7]  = ECALL;
        prog[1][8]  = r_type(7'h20, 3'b000, 10, 11, 7);
        prog[1][9]  = branch_op(3'b001, 10, 0, 13'd8);
        prog[1][10] = ECALL;
        prog[1][11] = addi_op(17, 0, `GECKO_ECALL_EXIT);
        prog[1][12] = addi_op(10, 0, 12'h022);
        prog[1][13] = ECALL;
        exp_bytes[1] = '{8'h3C, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[1] = 2;
        exp_exit[1]  = 8'h22;
        // ecalls at words 5, 7 and 9 lie on skipped paths
        test_name[2] = "branch_jal";
        prog[2][0]  = addi_op(17, 0, `GECKO_ECALL_PRINT);
        prog[2][1]  = addi_op(5, 0, 12'd3);
        prog[2][2]  = addi_op(6, 0, 12'd4);
        prog[2][3]  = addi_op(10, 0, 12'h011);
        prog[2][4]  = branch_op(3'b000, 5, 5, 13'd8);
        prog[2][5]  = ECALL;
        prog[2][6]  = branch_op(3'b001, 5, 6, 13'd8);
        prog[2][7]  = ECALL;
        prog[2][8]  = jal_op(10, 21'd8);
        prog[2][9]  = ECALL;
        prog[2][10] = ECALL;
        prog[2][11] = addi_op(10, 0, 12'h033);
        prog[2][12] = branch_op(3'b001, 5, 5, 13'd8);
        prog[2][13] = ECALL;
        prog[2][14] = addi_op(17, 0, `GECKO_ECALL_EXIT);
        prog[2][15] = ECALL;
        exp_bytes[2] = '{8'h24, 8'h33, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[2] = 2;
        exp_exit[2]  = 8'h33;
        // a print ecall after the exit must stay silent
        test_name[3] = "exit";
        prog[3][0] = addi_op(17, 0, `GECKO_ECALL_EXIT);
        prog[3][1] = addi_op(10, 0, 12'h05E);
        prog[3][2] = ECALL;
        prog[3][3] = addi_op(17, 0, `GECKO_ECALL_PRINT);
        prog[3][4] = ECALL;
        exp_bytes[3] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[3] = 0;
        exp_exit[3]  = 8'h5E;
        test_name[4] = "backpressure";
        exp_bytes[4] = '{"G", "E", "C", "K", "O", "!", 8'h00, 8'h00};
        exp_count[4] = 6;
        exp_exit[4]  = "!";
        prog[4][0] = addi_op(17, 0, `GECKO_ECALL_PRINT);
        for (int i = 0; i < 6; i++) begin
            prog[4][1 + 2 * i] = addi_op(10, 0, {4'h0, exp_bytes[4][i]});
            prog[4][2 + 2 * i] = ECALL;
        end
        prog[4][13] = addi_op(17, 0, `GECKO_ECALL_EXIT);
        prog[4][14] = ECALL;
    endtask

    task automatic check_prints(input int t);
        assert (got_bytes.size() <= exp_count[t]) else begin
            errors++;
            $display("%s: %0d byte(s) printed beyond the expected text",
                     test_name[t], got_bytes.size() - exp_count[t]);
        end
        assert (got_bytes.size() >= exp_count[t]) else begin
            errors++;
            $display("FAIL %s print count expected %0d actual %0d",
                     test_name[t], exp_count[t], got_bytes.size());
        end
        for (int i = 0; i < exp_count[t] && i < got_bytes.size(); i++) begin
            assert (got_bytes[i] === exp_bytes[t][i]) else begin
                errors++;
                $display("FAIL %s byte %0d expected %h actual %h",
                         test_name[t], i, exp_bytes[t][i], got_bytes[i]);
            end
        end
    endtask

    task automatic run_test(input int t);
        int cycles;
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i;
            prog_data <= prog[t][i];
        end
        got_bytes.delete();
        @(posedge clk);
        prog_we <= 1'b0;
        rst     <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!exit_valid && cycles < EXIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit_valid) begin
            timeouts++;
            $display("%s: exit_valid did not rise within %0d cycles", test_name[t], cycles);
            return;
        end
        assert (exit_code === exp_exit[t]) else begin
            errors++;
            $display("FAIL %s exit_code expected %h actual %h",
                     test_name[t], exp_exit[t], exit_code);
        end
        // stray prints after the exit show up here
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_prints(t);
    endtask

    initial begin
        rst         = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        print_ready = 1'b0;
        fill_table();
        repeat (5) @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- source/gecko_core.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_core (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                prog_we,
    input  logic [$clog2(`GECKO_MEM_WORDS)-1:0] prog_addr,
    input  logic [`GECKO_XLEN-1:0]              prog_data,
    output logic                                print_valid,
    input  logic                                print_ready,
    output logic [7:0]                          print_data,
    output logic                                exit_valid,
    output logic [7:0]                          exit_code
);
    import gecko_pkg::*;

    logic                   inst_valid;
    logic                   inst_ready;
    logic [`GECKO_XLEN-1:0] inst_data;
    logic [`GECKO_XLEN-1:0] inst_pc;

    logic                   issue_valid;
    logic                   issue_ready;
    gecko_exec_kind_t       issue_kind;
    gecko_alu_op_t          issue_alu_op;
    logic [`GECKO_XLEN-1:0] issue_a;
    logic [`GECKO_XLEN-1:0] issue_b;
    logic [`GECKO_XLEN-1:0] issue_imm;
    logic [`GECKO_XLEN-1:0] issue_pc;
    gecko_reg_addr_t        issue_rd;

    logic                   wb_valid;
    logic                   wb_done;
    gecko_reg_addr_t        wb_rd;
    logic [`GECKO_XLEN-1:0] wb_data;
    logic                   jump_valid;
    logic [`GECKO_XLEN-1:0] jump_target;

    logic                   if_req;
    logic [`GECKO_XLEN-1:0] if_addr;
    logic                   if_gnt;
    logic                   if_rvalid;
    logic [`GECKO_XLEN-1:0] if_rdata;
    logic                   dm_req;
    logic                   dm_we;
    logic [`GECKO_XLEN-1:0] dm_addr;
    logic [`GECKO_XLEN-1:0] dm_wdata;
    logic                   dm_gnt;
    logic                   dm_rvalid;
    logic [`GECKO_XLEN-1:0] dm_rdata;

    logic                                mem_en;
    logic                                mem_we;
    logic [$clog2(`GECKO_MEM_WORDS)-1:0] mem_addr;
    logic [`GECKO_XLEN-1:0]              mem_wdata;
    logic [`GECKO_XLEN-1:0]              mem_rdata;

    gecko_fetch u_fetch (
        .clk, .rst,
        .jump_valid, .jump_target,
        .if_req, .if_addr, .if_gnt, .if_rvalid, .if_rdata,
        .inst_valid, .inst_ready, .inst_data, .inst_pc
    );

    gecko_decode u_decode (
        .clk, .rst,
        .inst_valid, .inst_ready, .inst_data, .inst_pc,
        .issue_valid, .issue_ready, .issue_kind, .issue_alu_op,
        .issue_a, .issue_b, .issue_imm, .issue_pc, .issue_rd,
        .wb_valid, .wb_done, .wb_rd, .wb_data,
        .print_valid, .print_ready, .print_data,
        .exit_valid, .exit_code
    );

    gecko_execute u_execute (
        .clk, .rst,
        .issue_valid, .issue_ready, .issue_kind, .issue_alu_op,
        .issue_a, .issue_b, .issue_imm, .issue_pc, .issue_rd,
        .wb_valid, .wb_done, .wb_rd, .wb_data,
        .jump_valid, .jump_target,
        .dm_req, .dm_we, .dm_addr, .dm_wdata, .dm_gnt, .dm_rvalid, .dm_rdata
    );

    gecko_mem_arbiter u_mem_arbiter (
        .clk, .rst,
        .if_req, .if_addr, .if_gnt, .if_rvalid, .if_rdata,
        .dm_req, .dm_we, .dm_addr, .dm_wdata, .dm_gnt, .dm_rvalid, .dm_rdata,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    gecko_memory u_memory (
        .clk,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata,
        .prog_we, .prog_addr, .prog_data
    );

endmodule

//--- source/gecko_memory.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_memory (
    input  logic                                clk,
    input  logic                                mem_en,
    input  logic                                mem_we,
    input  logic [$clog2(`GECKO_MEM_WORDS)-1:0] mem_addr,
    input  logic [`GECKO_XLEN-1:0]              mem_wdata,
    output logic [`GECKO_XLEN-1:0]              mem_rdata,
    input  logic                                prog_we,
    input  logic [$clog2(`GECKO_MEM_WORDS)-1:0] prog_addr,
    input  logic [`GECKO_XLEN-1:0]              prog_data
);
    logic [`GECKO_XLEN-1:0] ram [`GECKO_MEM_WORDS];

    always_ff @(posedge clk) begin
        // program load goes first
        if (prog_we) begin
            ram[prog_addr] <= prog_data;
        end else if (mem_en && mem_we) begin
            ram[mem_addr] <= mem_wdata;
        end
        if (mem_en) begin
            mem_rdata <= ram[mem_addr];
        end
    end

endmodule

//--- source/gecko_mem_arbiter.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_mem_arbiter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 if_req,
    input  logic [`GECKO_XLEN-1:0]               if_addr,
    output logic                                 if_gnt,
    output logic                                 if_rvalid,
    output logic [`GECKO_XLEN-1:0]               if_rdata,
    input  logic                                 dm_req,
    input  logic                                 dm_we,
    input  logic [`GECKO_XLEN-1:0]               dm_addr,
    input  logic [`GECKO_XLEN-1:0]               dm_wdata,
    output logic                                 dm_gnt,
    output logic                                 dm_rvalid,
    output logic [`GECKO_XLEN-1:0]               dm_rdata,
    output logic                                 mem_en,
    output logic                                 mem_we,
    output logic [$clog2(`GECKO_MEM_WORDS)-1:0]  mem_addr,
    output logic [`GECKO_XLEN-1:0]               mem_wdata,
    input  logic [`GECKO_XLEN-1:0]               mem_rdata
);
    localparam int ADDR_W = $clog2(`GECKO_MEM_WORDS);

    // data side always wins
    assign dm_gnt = dm_req;
    assign if_gnt = if_req && !dm_req;

    assign mem_en    = dm_req || if_req;
    assign mem_we    = dm_req && dm_we;
    // byte address to word index
    assign mem_addr  = dm_req ? dm_addr[ADDR_W+1:2] : if_addr[ADDR_W+1:2];
    assign mem_wdata = dm_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_rvalid <= 1'b0;
            dm_rvalid <= 1'b0;
        end else begin
            if_rvalid <= if_gnt;
            dm_rvalid <= dm_gnt && !dm_we;
        end
    end

    assign if_rdata = mem_rdata;
    assign dm_rdata = mem_rdata;

endmodule

//--- source/gecko_execute.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_valid,
    output logic                        issue_ready,
    input  gecko_pkg::gecko_exec_kind_t issue_kind,
    input  gecko_pkg::gecko_alu_op_t    issue_alu_op,
    input  logic [`GECKO_XLEN-1:0]      issue_a,
    input  logic [`GECKO_XLEN-1:0]      issue_b,
    input  logic [`GECKO_XLEN-1:0]      issue_imm,
    input  logic [`GECKO_XLEN-1:0]      issue_pc,
    input  gecko_pkg::gecko_reg_addr_t  issue_rd,
    output logic                        wb_valid,
    output logic                        wb_done,
    output gecko_pkg::gecko_reg_addr_t  wb_rd,
    output logic [`GECKO_XLEN-1:0]      wb_data,
    output logic                        jump_valid,
    output logic [`GECKO_XLEN-1:0]      jump_target,
    output logic                        dm_req,
    output logic                        dm_we,
    output logic [`GECKO_XLEN-1:0]      dm_addr,
    output logic [`GECKO_XLEN-1:0]      dm_wdata,
    input  logic                        dm_gnt,
    input  logic                        dm_rvalid,
    input  logic [`GECKO_XLEN-1:0]      dm_rdata
);
    import gecko_pkg::*;

    logic [`GECKO_XLEN-1:0] alu_result;
    logic                   operands_equal;
    logic                   load_wait_q;
    logic                   issue_fire;

    always_comb begin
        case (issue_alu_op)
            ALU_SUB:    alu_result = issue_a - issue_b;
            ALU_AND:    alu_result = issue_a & issue_b;
            ALU_OR:     alu_result = issue_a | issue_b;
            ALU_XOR:    alu_result = issue_a ^ issue_b;
            ALU_PASS_B: alu_result = issue_b;
            default:    alu_result = issue_a + issue_b;
        endcase
    end

    assign operands_equal = (issue_a == issue_b);
    // memory op in progress blocks the next issue
    assign issue_ready = !dm_req && !load_wait_q;
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid    <= 1'b0;
            wb_done     <= 1'b0;
            jump_valid  <= 1'b0;
            dm_req      <= 1'b0;
            load_wait_q <= 1'b0;
        end else begin
            wb_valid   <= 1'b0;
            wb_done    <= 1'b0;
            jump_valid <= 1'b0;
            if (issue_fire) begin
                case (issue_kind)
                    EXEC_LOAD, EXEC_STORE: dm_req <= 1'b1;
                    EXEC_BRANCH_EQ: begin
                        jump_valid <= operands_equal;
                        wb_done    <= 1'b1;
                    end
                    EXEC_BRANCH_NE: begin
                        jump_valid <= !operands_equal;
                        wb_done    <= 1'b1;
                    end
                    EXEC_JUMP: begin
                        jump_valid <= 1'b1;
                        wb_valid   <= 1'b1;
                        wb_done    <= 1'b1;
                    end
                    default: begin
                        wb_valid <= 1'b1;
                        wb_done  <= 1'b1;
                    end
                endcase
            end
            if (dm_req && dm_gnt) begin
                dm_req      <= 1'b0;
                load_wait_q <= !dm_we;
                wb_done     <= dm_we;
            end
            if (load_wait_q && dm_rvalid) begin
                load_wait_q <= 1'b0;
                wb_valid    <= 1'b1;
                wb_done     <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            wb_rd       <= issue_rd;
            wb_data     <= (issue_kind == EXEC_JUMP) ? issue_pc + 4 : alu_result;
            jump_target <= issue_pc + issue_imm;
            dm_we       <= (issue_kind == EXEC_STORE);
            dm_addr     <= issue_a + issue_imm;
            dm_wdata    <= issue_b;
        end else if (load_wait_q && dm_rvalid) begin
            wb_data <= dm_rdata;
        end
    end

endmodule

//--- source/gecko_decode.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    output logic                        inst_ready,
    input  logic [`GECKO_XLEN-1:0]      inst_data,
    input  logic [`GECKO_XLEN-1:0]      inst_pc,
    output logic                        issue_valid,
    input  logic                        issue_ready,
    output gecko_pkg::gecko_exec_kind_t issue_kind,
    output gecko_pkg::gecko_alu_op_t    issue_alu_op,
    output logic [`GECKO_XLEN-1:0]      issue_a,
    output logic [`GECKO_XLEN-1:0]      issue_b,
    output logic [`GECKO_XLEN-1:0]      issue_imm,
    output logic [`GECKO_XLEN-1:0]      issue_pc,
    output gecko_pkg::gecko_reg_addr_t  issue_rd,
    input  logic                        wb_valid,
    input  logic                        wb_done,
    input  gecko_pkg::gecko_reg_addr_t  wb_rd,
    input  logic [`GECKO_XLEN-1:0]      wb_data,
    output logic                        print_valid,
    input  logic                        print_ready,
    output logic [7:0]                  print_data,
    output logic                        exit_valid,
    output logic [7:0]                  exit_code
);
    import gecko_pkg::*;

    logic [`GECKO_XLEN-1:0] regs [32];
    gecko_opcode_t          opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    gecko_reg_addr_t        rs1;
    gecko_reg_addr_t        rs2;
    logic [`GECKO_XLEN-1:0] rs1_val;
    logic [`GECKO_XLEN-1:0] rs2_val;
    logic [`GECKO_XLEN-1:0] a0_val;
    logic [`GECKO_XLEN-1:0] a7_val;
    gecko_exec_kind_t       dec_kind;
    gecko_alu_op_t          dec_alu_op;
    logic [`GECKO_XLEN-1:0] dec_imm;
    gecko_reg_addr_t        dec_rd;
    logic                   dec_use_imm;
    logic                   dec_ecall;
    logic                   busy_q;
    logic                   inst_fire;

    assign opcode = gecko_opcode_t'(inst_data[6:0]);
    assign funct3 = inst_data[14:12];
    assign funct7 = inst_data[31:25];
    assign rs1    = inst_data[19:15];
    assign rs2    = inst_data[24:20];

    // x0 always reads zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    assign a0_val  = regs[10];
    assign a7_val  = regs[17];

    always_comb begin
        dec_kind    = EXEC_ALU;
        dec_imm     = {{20{inst_data[31]}}, inst_data[31:20]};
        dec_rd      = inst_data[11:7];
        dec_use_imm = 1'b1;
        dec_ecall   = 1'b0;
        case (funct3)
            3'b100:  dec_alu_op = ALU_XOR;
            3'b110:  dec_alu_op = ALU_OR;
            3'b111:  dec_alu_op = ALU_AND;
            default: dec_alu_op = ALU_ADD;
        endcase
        case (opcode)
            OPCODE_OP: begin
                dec_use_imm = 1'b0;
                if (funct3 == 3'b000 && funct7[5]) begin
                    dec_alu_op = ALU_SUB;
                end
            end
            OPCODE_OP_IMM: ;
            OPCODE_LUI: begin
                dec_alu_op = ALU_PASS_B;
                dec_imm    = {inst_data[31:12], 12'b0};
            end
            OPCODE_LOAD: dec_kind = EXEC_LOAD;
            OPCODE_STORE: begin
                dec_kind    = EXEC_STORE;
                dec_imm     = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
                dec_rd      = '0;
                dec_use_imm = 1'b0;
            end
            OPCODE_BRANCH: begin
                dec_kind    = funct3[0] ? EXEC_BRANCH_NE : EXEC_BRANCH_EQ;
                dec_imm     = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                               inst_data[30:25], inst_data[11:8], 1'b0};
                dec_rd      = '0;
                dec_use_imm = 1'b0;
            end
            OPCODE_JAL: begin
                dec_kind = EXEC_JUMP;
                dec_imm  = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                            inst_data[20], inst_data[30:21], 1'b0};
            end
            OPCODE_SYSTEM: begin
                dec_ecall = (inst_data[31:7] == '0);
                dec_rd    = '0;
            end
            // anything else runs as a nop
            default: dec_rd = '0;
        endcase
    end

    assign inst_ready = !busy_q && !print_valid && !exit_valid;
    assign inst_fire  = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            issue_valid <= 1'b0;
            print_valid <= 1'b0;
            exit_valid  <= 1'b0;
        end else begin
            if (issue_valid && issue_ready) begin
                issue_valid <= 1'b0;
            end
            if (wb_done) begin
                busy_q <= 1'b0;
            end
            if (print_valid && print_ready) begin
                print_valid <= 1'b0;
            end
            if (inst_fire && dec_ecall) begin
                print_valid <= (a7_val == `GECKO_ECALL_PRINT);
                exit_valid  <= (a7_val == `GECKO_ECALL_EXIT);
            end else if (inst_fire) begin
                issue_valid <= 1'b1;
                busy_q      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_fire) begin
            issue_kind   <= dec_kind;
            issue_alu_op <= dec_alu_op;
            issue_a      <= rs1_val;
            issue_b      <= dec_use_imm ? dec_imm : rs2_val;
            issue_imm    <= dec_imm;
            issue_pc     <= inst_pc;
            issue_rd     <= dec_rd;
        end
        if (inst_fire && dec_ecall) begin
            print_data <= a0_val[7:0];
            exit_code  <= a0_val[7:0];
        end
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

//--- source/gecko_fetch.sv
`timescale 1ns/100ps

`include "gecko_macros.svh"

module gecko_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   jump_valid,
    input  logic [`GECKO_XLEN-1:0] jump_target,
    output logic                   if_req,
    output logic [`GECKO_XLEN-1:0] if_addr,
    input  logic                   if_gnt,
    input  logic                   if_rvalid,
    input  logic [`GECKO_XLEN-1:0] if_rdata,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output logic [`GECKO_XLEN-1:0] inst_data,
    output logic [`GECKO_XLEN-1:0] inst_pc
);
    import gecko_pkg::*;

    gecko_fetch_state_t     state_q;
    logic [`GECKO_XLEN-1:0] pc_q;
    logic [`GECKO_XLEN-1:0] word_q;
    logic                   kill_q;
    logic                   word_arrives;
    logic                   in_flight;

    assign word_arrives = (state_q == FETCH_WAIT) && if_rvalid && !kill_q;
    // a word from the old path is still on its way
    assign in_flight = ((state_q == FETCH_IDLE) && if_gnt) ||
                       ((state_q == FETCH_WAIT) && !if_rvalid);

    assign if_req     = (state_q == FETCH_IDLE);
    assign if_addr    = pc_q;
    assign inst_valid = word_arrives || (state_q == FETCH_HOLD);
    assign inst_data  = (state_q == FETCH_HOLD) ? word_q : if_rdata;
    assign inst_pc    = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_IDLE;
            pc_q    <= `GECKO_START_ADDR;
            kill_q  <= 1'b0;
        end else if (jump_valid) begin
            state_q <= in_flight ? FETCH_WAIT : FETCH_IDLE;
            pc_q    <= jump_target;
            kill_q  <= in_flight;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (if_gnt) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (if_rvalid) begin
                        kill_q <= 1'b0;
                        if (kill_q) begin
                            state_q <= FETCH_IDLE;
                        end else if (inst_ready) begin
                            state_q <= FETCH_IDLE;
                            pc_q    <= pc_q + 4;
                        end else begin
                            state_q <= FETCH_HOLD;
                        end
                    end
                end
                FETCH_HOLD: begin
                    if (inst_ready) begin
                        state_q <= FETCH_IDLE;
                        pc_q    <= pc_q + 4;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (word_arrives) begin
            word_q <= if_rdata;
        end
    end

endmodule

//--- source/gecko_pkg.sv
package gecko_pkg;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_SYSTEM = 7'b1110011
    } gecko_opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } gecko_alu_op_t;

    // what execute does with an issued op
    typedef enum logic [2:0] {
        EXEC_ALU,
        EXEC_LOAD,
        EXEC_STORE,
        EXEC_BRANCH_EQ,
        EXEC_BRANCH_NE,
        EXEC_JUMP
    } gecko_exec_kind_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_HOLD
    } gecko_fetch_state_t;

    typedef logic [4:0] gecko_reg_addr_t;

endpackage

//--- source/gecko_macros.svh
`ifndef GECKO_MACROS_SVH
`define GECKO_MACROS_SVH

// data and address width
`define GECKO_XLEN 32

// unified memory depth in words
`define GECKO_MEM_WORDS 256

`define GECKO_START_ADDR 32'h0000_0000

// a7 values seen by ecall
`define GECKO_ECALL_PRINT 1
`define GECKO_ECALL_EXIT 93

`endif
